//--- verilog/pim_bus_pkg.sv
package pim_bus_pkg;

    // CPU address and data word
    typedef logic [31:0] bus_word_t;

    // Upper address half selecting the cell window
    localparam int cell_window_lsb = 16;
    localparam logic [15:0] cell_window = 16'h4000;

    // Cell address fields, taken from the address word
    typedef logic [6:0] row_addr_t;
    typedef logic [8:0] col_addr_t;

    localparam int row_lsb = 9;
    localparam int col_lsb = 0;

    // Pulse parameters, taken from the data word
    typedef logic [16:0] pulse_width_t;
    typedef logic [4:0]  pulse_count_t;

    localparam int width_lsb = 5;
    localparam int count_lsb = 0;

    // Zero-point word toward the output buffer
    typedef logic signed [31:0] zp_data_t;

    // Status word bits
    localparam int status_idle_bit  = 0;
    localparam int status_valid_bit = 1;

endpackage

//--- verilog/pim_mode_pkg.sv
package pim_mode_pkg;

    // Codes 5 to 7 are reserved and do nothing
    typedef enum logic [2:0] {
        IDLE_MODE = 3'd0,
        ERASE     = 3'd1,
        PROGRAM   = 3'd2,
        READ      = 3'd3,
        ZP        = 3'd4
    } pim_mode_e;

    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        SETUP      = 2'b01,
        EXEC       = 2'b10,
        PROCESSING = 2'b11
    } seq_state_e;

    // Read exec countdown
    typedef logic [3:0] exec_cnt_t;

    // Output processing countdown
    typedef logic [1:0] proc_cnt_t;

    // Processing starts here, buffer read at this value then write at one below
    localparam proc_cnt_t proc_start = 2'd2;

endpackage

//--- verilog/pim_bus_regs.sv
`timescale 1ns/1ns

module pim_bus_regs
    import pim_bus_pkg::*;
    import pim_mode_pkg::*;
#(
    parameter bus_word_t mode_addr   = 32'h4100_0000,
    parameter bus_word_t zp_addr     = 32'h4200_0000,
    parameter bus_word_t status_addr = 32'h4300_0000
) (
    input  logic         clk_i,
    input  logic         rst_ni,

    input  bus_word_t    address_i,
    input  bus_word_t    data_i,
    input  logic         seq_idle_i,
    input  logic         read_data_ready_i,

    output logic         mode_wr_o,
    output logic         cell_wr_o,
    output logic         zp_wr_o,
    output pim_mode_e    mode_o,
    output row_addr_t    row_addr_o,
    output col_addr_t    col_addr_o,
    output pulse_width_t pulse_width_o,
    output pulse_width_t pulse_width_in_o,
    output pulse_count_t pulse_count_in_o,
    output bus_word_t    data_o
);

    logic status_rd;
    logic data_valid;
    logic pulse_mode;
    logic cell_mode;

    // Address decode, the address itself is the command
    assign mode_wr_o = (address_i == mode_addr);
    assign cell_wr_o = (address_i[$bits(bus_word_t)-1:cell_window_lsb] == cell_window);
    assign zp_wr_o   = (address_i == zp_addr);
    assign status_rd = (address_i == status_addr);

    assign pulse_mode = (mode_o == ERASE) || (mode_o == PROGRAM);
    assign cell_mode  = pulse_mode || (mode_o == READ);

    // Pulse parameters go straight to the timer on the cell write
    assign pulse_width_in_o = cell_wr_o ? data_i[width_lsb +: $bits(pulse_width_t)] : '0;
    assign pulse_count_in_o = cell_wr_o ? data_i[count_lsb +: $bits(pulse_count_t)] : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mode_o <= IDLE_MODE;
        end else if (mode_wr_o) begin
            mode_o <= pim_mode_e'(data_i[$bits(pim_mode_e)-1:0]);
        end
    end

    // Cell address and pulse width
    always_ff @(posedge clk_i) begin
        if (cell_wr_o && cell_mode) begin
            row_addr_o <= address_i[row_lsb +: $bits(row_addr_t)];
            col_addr_o <= address_i[col_lsb +: $bits(col_addr_t)];
        end
        if (cell_wr_o && pulse_mode) begin
            pulse_width_o <= pulse_width_in_o;
        end
    end

    // Sticky until the next mode write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_valid <= 1'b0;
        end else if (mode_wr_o) begin
            data_valid <= 1'b0;
        end else if (read_data_ready_i) begin
            data_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_o <= '0;
        end else begin
            data_o <= '0;
            if (status_rd) begin
                data_o[status_idle_bit]  <= seq_idle_i;
                data_o[status_valid_bit] <= data_valid;
            end
        end
    end

endmodule

//--- verilog/pim_pulse_timer.sv
`timescale 1ns/1ns

module pim_pulse_timer
    import pim_bus_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         load_i,
    input  pulse_width_t width_i,
    input  pulse_count_t count_i,
    input  pulse_width_t reload_width_i,

    output pulse_width_t width_cnt_o,
    output pulse_count_t count_cnt_o
);

    // One pulse is width cycles high plus one low cycle at width zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            width_cnt_o <= '0;
            count_cnt_o <= '0;
        end else if (load_i) begin
            width_cnt_o <= width_i;
            count_cnt_o <= count_i;
        end else if (count_cnt_o != '0) begin
            if (width_cnt_o != '0) begin
                width_cnt_o <= width_cnt_o - 1'b1;
            end else begin
                // Gap cycle done, start the next pulse
                width_cnt_o <= reload_width_i;
                count_cnt_o <= count_cnt_o - 1'b1;
            end
        end else begin
            width_cnt_o <= '0;
        end
    end

endmodule

//--- verilog/pim_read_timer.sv
`timescale 1ns/1ns

module pim_read_timer
    import pim_mode_pkg::*;
#(
    // Valid range 3 to 15
    parameter int read_exec_cycles = 9
) (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  logic      load_i,
    input  logic      active_i,

    output exec_cnt_t exec_cnt_o,
    output proc_cnt_t proc_cnt_o
);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exec_cnt_o <= '0;
            proc_cnt_o <= '0;
        end else if (load_i) begin
            exec_cnt_o <= exec_cnt_t'(read_exec_cycles);
            proc_cnt_o <= '0;
        end else if (!active_i) begin
            exec_cnt_o <= '0;
            proc_cnt_o <= '0;
        end else if (exec_cnt_o != '0) begin
            exec_cnt_o <= exec_cnt_o - 1'b1;
            // Processing follows the last exec cycle directly
            if (exec_cnt_o == exec_cnt_t'(1)) begin
                proc_cnt_o <= proc_start;
            end
        end else if (proc_cnt_o != '0) begin
            proc_cnt_o <= proc_cnt_o - 1'b1;
        end
    end

endmodule

//--- verilog/pim_seq_fsm.sv
`timescale 1ns/1ns

module pim_seq_fsm
    import pim_bus_pkg::*;
    import pim_mode_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         mode_wr_i,
    input  logic         cell_wr_i,
    input  logic         zp_wr_i,
    input  pim_mode_e    mode_i,
    input  row_addr_t    row_addr_i,
    input  col_addr_t    col_addr_i,
    input  bus_word_t    data_i,
    input  pulse_width_t width_cnt_i,
    input  pulse_count_t count_cnt_i,
    input  exec_cnt_t    exec_cnt_i,
    input  proc_cnt_t    proc_cnt_i,

    output logic         setup_done_o,
    output logic         pulse_load_o,
    output logic         read_load_o,
    output logic         read_active_o,
    output logic         seq_idle_o,
    output logic         read_data_ready_o,

    output logic         pim_en_o,
    output pim_mode_e    pim_mode_o,
    output exec_cnt_t    exec_cnt_o,
    output row_addr_t    row_addr_o,
    output col_addr_t    col_addr_o,
    output logic         zp_en_o,
    output zp_data_t     zp_data_o,
    output logic         pim_out_buf_r_en_o,
    output logic         read_buf_w_en_o
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       pulse_mode;
    logic       read_mode;
    logic       pulse_last;

    assign pulse_mode = (mode_i == ERASE) || (mode_i == PROGRAM);
    assign read_mode  = (mode_i == READ);

    assign setup_done_o = (state_q == SETUP) &&
                          (((pulse_mode || read_mode) && cell_wr_i) ||
                           ((mode_i == ZP) && zp_wr_i));

    assign pulse_load_o  = setup_done_o && pulse_mode;
    assign read_load_o   = setup_done_o && read_mode;
    assign read_active_o = read_mode && ((state_q == EXEC) || (state_q == PROCESSING));

    assign seq_idle_o        = (state_q == IDLE);
    assign read_data_ready_o = (state_q == EXEC) && read_mode && (exec_cnt_i == exec_cnt_t'(2));

    // Gap cycle of the final pulse
    assign pulse_last = (count_cnt_i <= pulse_count_t'(1)) && (width_cnt_i == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (mode_wr_i) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                if (setup_done_o) begin
                    state_d = (mode_i == ZP) ? IDLE : EXEC;
                end
            end
            EXEC: begin
                if (pulse_mode) begin
                    if (pulse_last) begin
                        state_d = IDLE;
                    end
                end else if (read_mode) begin
                    if (exec_cnt_i <= exec_cnt_t'(1)) begin
                        state_d = PROCESSING;
                    end
                end else begin
                    // Reserved or idle mode has nothing to run
                    state_d = IDLE;
                end
            end
            PROCESSING: begin
                if (proc_cnt_i <= proc_cnt_t'(1)) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Driver, zero-point and buffer strobes
    always_comb begin
        pim_en_o           = 1'b0;
        pim_mode_o         = IDLE_MODE;
        exec_cnt_o         = '0;
        row_addr_o         = '0;
        col_addr_o         = '0;
        zp_en_o            = 1'b0;
        zp_data_o          = '0;
        pim_out_buf_r_en_o = 1'b0;
        read_buf_w_en_o    = 1'b0;
        case (state_q)
            SETUP: begin
                if (mode_i == ZP) begin
                    zp_en_o   = 1'b1;
                    zp_data_o = zp_data_t'(data_i);
                end
            end
            EXEC: begin
                if (pulse_mode || read_mode) begin
                    pim_mode_o = mode_i;
                    row_addr_o = row_addr_i;
                    col_addr_o = col_addr_i;
                end
                if (pulse_mode) begin
                    pim_en_o = (width_cnt_i != '0) && (count_cnt_i != '0);
                end else if (read_mode) begin
                    pim_en_o   = (exec_cnt_i != '0);
                    exec_cnt_o = exec_cnt_i;
                end
            end
            PROCESSING: begin
                pim_mode_o         = mode_i;
                col_addr_o         = col_addr_i;
                pim_out_buf_r_en_o = (proc_cnt_i == proc_start);
                read_buf_w_en_o    = read_mode && (proc_cnt_i == proc_start - 1'b1);
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/pim_ctrl_top.sv
`timescale 1ns/1ns

module pim_ctrl_top
    import pim_bus_pkg::*;
    import pim_mode_pkg::*;
#(
    parameter bus_word_t mode_addr        = 32'h4100_0000,
    parameter bus_word_t zp_addr          = 32'h4200_0000,
    parameter bus_word_t status_addr      = 32'h4300_0000,
    parameter int        read_exec_cycles = 9
) (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  bus_word_t address_i,
    input  bus_word_t data_i,
    output bus_word_t data_o,

    output logic      pim_en_o,
    output pim_mode_e pim_mode_o,
    output exec_cnt_t exec_cnt_o,
    output row_addr_t row_addr_o,
    output col_addr_t col_addr_o,

    output logic      zp_en_o,
    output zp_data_t  zp_data_o,

    output logic      pim_out_buf_r_en_o,
    output logic      read_buf_w_en_o
);

    logic         mode_wr;
    logic         cell_wr;
    logic         zp_wr;
    pim_mode_e    mode;
    row_addr_t    row_addr;
    col_addr_t    col_addr;
    pulse_width_t pulse_width;
    pulse_width_t pulse_width_in;
    pulse_count_t pulse_count_in;
    logic         seq_idle;
    logic         read_data_ready;
    logic         pulse_load;
    logic         read_load;
    logic         read_active;
    pulse_width_t width_cnt;
    pulse_count_t count_cnt;
    exec_cnt_t    exec_cnt;
    proc_cnt_t    proc_cnt;

    pim_bus_regs #(
        .mode_addr   (mode_addr),
        .zp_addr     (zp_addr),
        .status_addr (status_addr)
    ) u_bus_regs (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .address_i         (address_i),
        .data_i            (data_i),
        .seq_idle_i        (seq_idle),
        .read_data_ready_i (read_data_ready),
        .mode_wr_o         (mode_wr),
        .cell_wr_o         (cell_wr),
        .zp_wr_o           (zp_wr),
        .mode_o            (mode),
        .row_addr_o        (row_addr),
        .col_addr_o        (col_addr),
        .pulse_width_o     (pulse_width),
        .pulse_width_in_o  (pulse_width_in),
        .pulse_count_in_o  (pulse_count_in),
        .data_o            (data_o)
    );

    pim_pulse_timer u_pulse_timer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .load_i         (pulse_load),
        .width_i        (pulse_width_in),
        .count_i        (pulse_count_in),
        .reload_width_i (pulse_width),
        .width_cnt_o    (width_cnt),
        .count_cnt_o    (count_cnt)
    );

    pim_read_timer #(
        .read_exec_cycles (read_exec_cycles)
    ) u_read_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .load_i     (read_load),
        .active_i   (read_active),
        .exec_cnt_o (exec_cnt),
        .proc_cnt_o (proc_cnt)
    );

    pim_seq_fsm u_seq_fsm (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .mode_wr_i          (mode_wr),
        .cell_wr_i          (cell_wr),
        .zp_wr_i            (zp_wr),
        .mode_i             (mode),
        .row_addr_i         (row_addr),
        .col_addr_i         (col_addr),
        .data_i             (data_i),
        .width_cnt_i        (width_cnt),
        .count_cnt_i        (count_cnt),
        .exec_cnt_i         (exec_cnt),
        .proc_cnt_i         (proc_cnt),
        .setup_done_o       (),
        .pulse_load_o       (pulse_load),
        .read_load_o        (read_load),
        .read_active_o      (read_active),
        .seq_idle_o         (seq_idle),
        .read_data_ready_o  (read_data_ready),
        .pim_en_o           (pim_en_o),
        .pim_mode_o         (pim_mode_o),
        .exec_cnt_o         (exec_cnt_o),
        .row_addr_o         (row_addr_o),
        .col_addr_o         (col_addr_o),
        .zp_en_o            (zp_en_o),
        .zp_data_o          (zp_data_o),
        .pim_out_buf_r_en_o (pim_out_buf_r_en_o),
        .read_buf_w_en_o    (read_buf_w_en_o)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int half_period  = 5;
    localparam int reset_cycles = 3;

    initial begin
        clk_o = 1'b0;
        forever #half_period clk_o = ~clk_o;
    end

    // Release just after the edge so no flop sees it mid-update
    initial begin
        rst_no = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

//--- test/pim_ctrl_assertions.sv
`timescale 1ns/1ns

module pim_ctrl_assertions
    import pim_mode_pkg::*;
(
    input logic      clk_i,
    input logic      rst_ni,
    input logic      pim_en_i,
    input exec_cnt_t exec_cnt_i,
    input logic      zp_en_i,
    input logic      pim_out_buf_r_en_i,
    input logic      read_buf_w_en_i
);

    zp_pim_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(zp_en_i && pim_en_i))
        else $error("zp_en_o and pim_en_o high in the same cycle");

    // Read countdown only runs while the drivers are on
    exec_cnt_drives: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (exec_cnt_i != '0) |-> pim_en_i)
        else $error("exec_cnt_o nonzero with pim_en_o low");

    buf_read_then_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pim_out_buf_r_en_i |=> read_buf_w_en_i)
        else $error("pim_out_buf_r_en_o not followed by read_buf_w_en_o");

    strobes_low_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !(pim_en_i || zp_en_i || pim_out_buf_r_en_i || read_buf_w_en_i))
        else $error("strobe high during reset");

endmodule

bind pim_ctrl_top pim_ctrl_assertions u_assertions (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pim_en_i           (pim_en_o),
    .exec_cnt_i         (exec_cnt_o),
    .zp_en_i            (zp_en_o),
    .pim_out_buf_r_en_i (pim_out_buf_r_en_o),
    .read_buf_w_en_i    (read_buf_w_en_o)
);

//--- test/pim_ctrl_tb.sv
`timescale 1ns/1ns

module pim_ctrl_tb
    import pim_bus_pkg::*;
    import pim_mode_pkg::*;
();

    localparam bus_word_t mode_addr        = 32'h4100_0000;
    localparam bus_word_t zp_addr          = 32'h4200_0000;
    localparam bus_word_t status_addr      = 32'h4300_0000;
    localparam int        read_exec_cycles = 9;
    localparam int        run_limit        = 3000;

    logic        clk;
    logic        rst_n;
    bus_word_t   address;
    bus_word_t   data_in;
    bus_word_t   data_out;
    logic        pim_en;
    pim_mode_e   pim_mode;
    exec_cnt_t   exec_cnt;
    row_addr_t   row_addr;
    col_addr_t   col_addr;
    logic        zp_en;
    zp_data_t    zp_data;
    logic        buf_r_en;
    logic        buf_w_en;
    logic [31:0] lfsr_q;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    pim_ctrl_top #(
        .mode_addr        (mode_addr),
        .zp_addr          (zp_addr),
        .status_addr      (status_addr),
        .read_exec_cycles (read_exec_cycles)
    ) dut (
        .clk_i              (clk),
        .rst_ni             (rst_n),
        .address_i          (address),
        .data_i             (data_in),
        .data_o             (data_out),
        .pim_en_o           (pim_en),
        .pim_mode_o         (pim_mode),
        .exec_cnt_o         (exec_cnt),
        .row_addr_o         (row_addr),
        .col_addr_o         (col_addr),
        .zp_en_o            (zp_en),
        .zp_data_o          (zp_data),
        .pim_out_buf_r_en_o (buf_r_en),
        .read_buf_w_en_o    (buf_w_en)
    );

    task automatic stop_on_error(input string reason);
        $display("Regression failed");
        $fatal(1, "%s", reason);
    endtask

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_on_error("value check failed");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            stop_on_error("value check failed");
        end
    endtask

    task automatic check_mode(input string name, input pim_mode_e got, input pim_mode_e exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
            stop_on_error("value check failed");
        end
    endtask

    task automatic check_count(input string name, input exec_cnt_t got, input exec_cnt_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
            stop_on_error("value check failed");
        end
    endtask

    task automatic check_row(input string name, input row_addr_t got, input row_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_on_error("value check failed");
        end
    endtask

    task automatic check_col(input string name, input col_addr_t got, input col_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_on_error("value check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_bus(input bus_word_t addr, input bus_word_t data);
        address = addr;
        data_in = data;
        next_cycle();
        address = '0;
        data_in = '0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == 20) begin
                stop_on_error("reset was never released");
            end
            @(posedge clk);
            cycles++;
        end
        #1;
    endtask

    // Poll the status word until the idle bit shows
    task automatic wait_idle(output bus_word_t status);
        int tries;
        tries  = 0;
        status = '0;
        while (status[0] !== 1'b1) begin
            if (tries == 32) begin
                stop_on_error("sequencer did not return to idle");
            end
            write_bus(status_addr, '0);
            status = data_out;
            tries++;
        end
    endtask

    task automatic test_reset_status();
        check_word("data_o", data_out, '0);
        check_bit("pim_en_o", pim_en, 1'b0);
        check_bit("zp_en_o", zp_en, 1'b0);
        check_bit("pim_out_buf_r_en_o", buf_r_en, 1'b0);
        check_bit("read_buf_w_en_o", buf_w_en, 1'b0);
        check_mode("pim_mode_o", pim_mode, IDLE_MODE);
        write_bus(status_addr, '0);
        check_word("data_o", data_out, 32'h1);
    endtask

    task automatic test_pulse_train(input pim_mode_e mode, input int width, input int count);
        logic [31:0] bits;
        row_addr_t   row;
        col_addr_t   col;
        bus_word_t   status;
        draw_bits(7, bits);
        row = row_addr_t'(bits);
        draw_bits(9, bits);
        col = col_addr_t'(bits);
        write_bus(mode_addr, bus_word_t'(mode));
        write_bus({16'h4000, row, col}, (bus_word_t'(width) << 5) | bus_word_t'(count));
        for (int p = 0; p < count; p++) begin
            for (int w = 0; w < width; w++) begin
                check_bit("pim_en_o", pim_en, 1'b1);
                check_mode("pim_mode_o", pim_mode, mode);
                check_row("row_addr_o", row_addr, row);
                check_col("col_addr_o", col_addr, col);
                next_cycle();
            end
            // Low cycle between pulses
            check_bit("pim_en_o", pim_en, 1'b0);
            check_mode("pim_mode_o", pim_mode, mode);
            next_cycle();
        end
        check_bit("pim_en_o", pim_en, 1'b0);
        check_mode("pim_mode_o", pim_mode, IDLE_MODE);
        wait_idle(status);
        check_word("data_o", status, 32'h1);
    endtask

    task automatic test_read();
        logic [31:0] bits;
        row_addr_t   row;
        col_addr_t   col;
        bus_word_t   status;
        draw_bits(7, bits);
        row = row_addr_t'(bits);
        draw_bits(9, bits);
        col = col_addr_t'(bits);
        write_bus(mode_addr, bus_word_t'(READ));
        write_bus({16'h4000, row, col}, '0);
        for (int k = read_exec_cycles; k >= 1; k--) begin
            check_count("exec_cnt_o", exec_cnt, exec_cnt_t'(k));
            check_bit("pim_en_o", pim_en, 1'b1);
            check_mode("pim_mode_o", pim_mode, READ);
            check_row("row_addr_o", row_addr, row);
            check_col("col_addr_o", col_addr, col);
            check_bit("pim_out_buf_r_en_o", buf_r_en, 1'b0);
            next_cycle();
        end
        // Processing, buffer read then buffer write
        check_bit("pim_en_o", pim_en, 1'b0);
        check_count("exec_cnt_o", exec_cnt, '0);
        check_bit("pim_out_buf_r_en_o", buf_r_en, 1'b1);
        check_bit("read_buf_w_en_o", buf_w_en, 1'b0);
        next_cycle();
        check_bit("pim_out_buf_r_en_o", buf_r_en, 1'b0);
        check_bit("read_buf_w_en_o", buf_w_en, 1'b1);
        next_cycle();
        check_bit("pim_out_buf_r_en_o", buf_r_en, 1'b0);
        check_bit("read_buf_w_en_o", buf_w_en, 1'b0);
        check_bit("pim_en_o", pim_en, 1'b0);
        wait_idle(status);
        check_word("data_o", status, 32'h3);
    endtask

    task automatic test_zero_point();
        logic [31:0] word;
        bus_word_t   status;
        write_bus(mode_addr, bus_word_t'(ZP));
        // Mode write has cleared data valid, and SETUP is not idle
        write_bus(status_addr, '0);
        check_word("data_o", data_out, '0);
        for (int i = 0; i < 4; i++) begin
            draw_bits(32, word);
            address = '0;
            data_in = word;
            #1;
            check_bit("zp_en_o", zp_en, 1'b1);
            check_word("zp_data_o", bus_word_t'(zp_data), word);
            check_bit("pim_en_o", pim_en, 1'b0);
            next_cycle();
        end
        draw_bits(32, word);
        address = zp_addr;
        data_in = word;
        #1;
        check_bit("zp_en_o", zp_en, 1'b1);
        check_word("zp_data_o", bus_word_t'(zp_data), word);
        check_bit("pim_en_o", pim_en, 1'b0);
        next_cycle();
        address = '0;
        data_in = '0;
        check_bit("zp_en_o", zp_en, 1'b0);
        check_bit("pim_en_o", pim_en, 1'b0);
        wait_idle(status);
        check_word("data_o", status, 32'h1);
    endtask

    initial begin
        repeat (run_limit) @(posedge clk);
        stop_on_error("run did not finish within the cycle limit");
    end

    initial begin
        address = '0;
        data_in = '0;
        lfsr_q  = 32'd72530;
        wait_reset_release();
        test_reset_status();
        test_pulse_train(PROGRAM, 3, 2);
        test_pulse_train(ERASE, 1, 4);
        test_read();
        test_zero_point();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- pim_ctrl_top.f
verilog/pim_bus_pkg.sv
verilog/pim_mode_pkg.sv
verilog/pim_bus_regs.sv
verilog/pim_pulse_timer.sv
verilog/pim_read_timer.sv
verilog/pim_seq_fsm.sv
verilog/pim_ctrl_top.sv
test/tb_clock_gen.sv
test/pim_ctrl_assertions.sv
test/pim_ctrl_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = pim_ctrl_tb
FILELIST = pim_ctrl_top.f
MDIR     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)
